// File: filelist.f
source/csr_pkg.sv
source/csr_access_if.sv
source/csr_request_ctrl.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_unit.sv
tests/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module csr_unit_tb -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csr_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: source/csr_access_if.sv
/* Committed CSR access from the request controller to the register blocks */

`timescale 1ns/1ns

interface csr_access_if;

    logic [11:0] addr;
    logic [csr_pkg::XLEN-1:0] write_data;
    logic write;

    // Zero when the block does not own addr
    logic [csr_pkg::XLEN-1:0] trap_rdata;
    logic [csr_pkg::XLEN-1:0] count_rdata;

    modport ctrl (
        output addr, write_data, write,
        input trap_rdata, count_rdata
    );

    modport trap (
        input addr, write_data, write,
        output trap_rdata
    );

    modport counter (
        input addr, write_data, write,
        output count_rdata
    );

endinterface

// File: source/csr_counters.sv
/* 64-bit mcycle and minstret counters with half-word writes and user aliases */

`timescale 1ns/1ns

module csr_counters (
    input logic clk,
    input logic rst,
    input logic [csr_pkg::RETIRE_W-1:0] retire_count,
    csr_access_if.counter bus
);

    logic [csr_pkg::COUNTER_W-1:0] mcycle;
    logic [csr_pkg::COUNTER_W-1:0] minstret;

    // A write to either half replaces it and skips this cycle's increment
    function automatic logic [csr_pkg::COUNTER_W-1:0] count_next(
        input logic [csr_pkg::COUNTER_W-1:0] cur,
        input logic [11:0] lo_addr,
        input logic [11:0] hi_addr,
        input logic [csr_pkg::RETIRE_W-1:0] inc
    );
        logic [csr_pkg::COUNTER_W-1:0] nxt;
        logic wr_lo;
        logic wr_hi;
        wr_lo = bus.write && (bus.addr == lo_addr);
        wr_hi = bus.write && (bus.addr == hi_addr);
        nxt = cur + csr_pkg::COUNTER_W'(inc);
        if (wr_lo || wr_hi) begin
            nxt = cur;
        end
        if (wr_lo) begin
            nxt[csr_pkg::XLEN-1:0] = bus.write_data;
        end
        if (wr_hi) begin
            nxt[csr_pkg::COUNTER_W-1:csr_pkg::XLEN] = bus.write_data;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= count_next(mcycle, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MCYCLEH, 2'd1);
            minstret <= count_next(minstret, csr_pkg::CSR_MINSTRET, csr_pkg::CSR_MINSTRETH,
                                   retire_count);
        end
    end

    always_comb begin
        case (bus.addr)
            csr_pkg::CSR_MCYCLE, csr_pkg::CSR_CYCLE:
                bus.count_rdata = mcycle[csr_pkg::XLEN-1:0];
            csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_CYCLEH:
                bus.count_rdata = mcycle[csr_pkg::COUNTER_W-1:csr_pkg::XLEN];
            csr_pkg::CSR_MINSTRET, csr_pkg::CSR_INSTRET:
                bus.count_rdata = minstret[csr_pkg::XLEN-1:0];
            csr_pkg::CSR_MINSTRETH, csr_pkg::CSR_INSTRETH:
                bus.count_rdata = minstret[csr_pkg::COUNTER_W-1:csr_pkg::XLEN];
            default: bus.count_rdata = '0;
        endcase
    end

endmodule

// File: source/csr_pkg.sv
/* Shared widths, CSR addresses, constant register values,
   and the CSR op and cause code enums */

package csr_pkg;

    localparam int XLEN = 32;
    localparam int COUNTER_W = 64;
    localparam int ECODE_W = 5;
    localparam int RETIRE_W = 2;

    ////////////////////////////////////////////////////////////////////////////
    // CSR addresses

    // Machine trap setup and handling
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MISA = 12'h301;
    localparam logic [11:0] CSR_MIE = 12'h304;
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC = 12'h341;
    localparam logic [11:0] CSR_MCAUSE = 12'h342;
    localparam logic [11:0] CSR_MTVAL = 12'h343;
    localparam logic [11:0] CSR_MIP = 12'h344;
    localparam logic [11:0] CSR_MHARTID = 12'hF14;

    // Machine counters
    localparam logic [11:0] CSR_MCYCLE = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

    // User read-only aliases
    localparam logic [11:0] CSR_CYCLE = 12'hC00;
    localparam logic [11:0] CSR_INSTRET = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH = 12'hC80;
    localparam logic [11:0] CSR_INSTRETH = 12'hC82;

    ////////////////////////////////////////////////////////////////////////////
    // Constant registers and field positions

    // MXL=1 for 32-bit with the base integer ISA only
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;
    localparam logic [XLEN-1:0] HART_ID = 32'h0;

    // Same positions serve mie/mip as software, timer, external
    localparam int MIE_BIT = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB = 11;

    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // Exception causes
    typedef enum logic [ECODE_W-1:0] {
        INST_ADDR_MISALIGNED = 5'd0,
        ILLEGAL_INST = 5'd2,
        BREAKPOINT = 5'd3,
        LOAD_ADDR_MISALIGNED = 5'd4,
        STORE_ADDR_MISALIGNED = 5'd6,
        ECALL_M = 5'd11
    } ecode_e;

    // Interrupt cause codes
    localparam logic [ECODE_W-1:0] M_SOFTWARE_INT = 5'd3;
    localparam logic [ECODE_W-1:0] M_TIMER_INT = 5'd7;
    localparam logic [ECODE_W-1:0] M_EXTERNAL_INT = 5'd11;

endpackage

// File: source/csr_request_ctrl.sv
/* CSR request latch, commit and writeback sequencing,
   RW/RS/RC arithmetic and read data merge */

`timescale 1ns/1ns

module csr_request_ctrl (
    input logic clk,
    input logic rst,

    input logic issue_valid,
    input csr_pkg::csr_op_e issue_op,
    input logic [11:0] issue_addr,
    input logic [csr_pkg::XLEN-1:0] issue_data,
    output logic ready,

    output logic done,
    output logic [csr_pkg::XLEN-1:0] rd,
    input logic ack,

    output logic processing_csr,

    csr_access_if.ctrl bus
);

    logic busy;
    logic accept;
    logic commit;

    csr_pkg::csr_op_e req_op;
    logic [11:0] req_addr;
    logic [csr_pkg::XLEN-1:0] req_data;

    logic [csr_pkg::XLEN-1:0] old_value;
    logic [csr_pkg::XLEN-1:0] new_value;

    assign ready = ~busy;
    assign accept = issue_valid & ready;
    assign processing_csr = busy | issue_valid;

    // First busy cycle commits; done covers the rest until ack
    assign commit = busy & ~done;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            busy <= (busy & ~ack) | accept;
            done <= (done & ~ack) | commit;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op <= issue_op;
            req_addr <= issue_addr;
            req_data <= issue_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-modify-write

    assign old_value = bus.trap_rdata | bus.count_rdata;

    always_comb begin
        case (req_op)
            csr_pkg::CSR_RS: new_value = old_value | req_data;
            csr_pkg::CSR_RC: new_value = old_value & ~req_data;
            default: new_value = req_data;
        endcase
    end

    assign bus.addr = req_addr;
    assign bus.write_data = new_value;
    // Top two address bits set marks a read-only CSR
    assign bus.write = commit & (req_addr[11:10] != 2'b11);

    always_ff @(posedge clk) begin
        if (commit) begin
            rd <= old_value;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        accept && (issue_addr[11:10] == 2'b11) |=> !bus.write)
        else $error("write strobe on a read-only CSR");

    assert property (@(posedge clk) disable iff (rst) done |-> !ready)
        else $error("done raised while ready");

endmodule

// File: source/csr_trap_regs.sv
/* Machine trap registers: mstatus, mtvec, mepc, mcause, mtval, mscratch,
   mie, mip, plus trap entry/return and interrupt cause selection */

`timescale 1ns/1ns

module csr_trap_regs (
    input logic clk,
    input logic rst,

    input logic exception_valid,
    input csr_pkg::ecode_e exception_code,
    input logic [csr_pkg::XLEN-1:0] exception_pc,
    input logic [csr_pkg::XLEN-1:0] exception_tval,
    input logic mret,
    input logic interrupt_taken,

    input logic m_software,
    input logic m_timer,
    input logic m_external,

    output logic [csr_pkg::XLEN-1:0] exception_target_pc,
    output logic [csr_pkg::XLEN-1:0] epc,
    output logic interrupt_pending,

    csr_access_if.trap bus
);

    logic mstatus_mie;
    logic mstatus_mpie;
    logic [csr_pkg::XLEN-1:2] mtvec;
    logic [csr_pkg::XLEN-1:2] mepc;
    logic mcause_int;
    logic [csr_pkg::ECODE_W-1:0] mcause_code;
    logic [csr_pkg::XLEN-1:0] mtval;
    logic [csr_pkg::XLEN-1:0] mscratch;

    // Ordered {external, timer, software}
    logic [2:0] mie;
    logic [2:0] mip;
    logic [csr_pkg::ECODE_W-1:0] interrupt_cause;

    logic trap_entry;
    logic [csr_pkg::XLEN-1:0] wdata;

    function automatic logic wr_en(input logic [11:0] a);
        return bus.write && (bus.addr == a);
    endfunction

    // Spread the three interrupt bits to their mie/mip positions
    function automatic logic [csr_pkg::XLEN-1:0] irq_word(input logic [2:0] bits);
        logic [csr_pkg::XLEN-1:0] w;
        w = '0;
        w[csr_pkg::MIE_BIT] = bits[0];
        w[csr_pkg::MPIE_BIT] = bits[1];
        w[csr_pkg::MPP_LSB] = bits[2];
        return w;
    endfunction

    // Only causes this hart can raise may be written
    function automatic logic mcause_legal(input logic [csr_pkg::XLEN-1:0] value);
        logic [csr_pkg::ECODE_W-1:0] code;
        code = value[csr_pkg::ECODE_W-1:0];
        if (value[csr_pkg::XLEN-1]) begin
            return code inside {csr_pkg::M_SOFTWARE_INT, csr_pkg::M_TIMER_INT,
                                csr_pkg::M_EXTERNAL_INT};
        end
        return code inside {csr_pkg::INST_ADDR_MISALIGNED, csr_pkg::ILLEGAL_INST,
                            csr_pkg::BREAKPOINT, csr_pkg::LOAD_ADDR_MISALIGNED,
                            csr_pkg::STORE_ADDR_MISALIGNED, csr_pkg::ECALL_M};
    endfunction

    assign wdata = bus.write_data;
    assign trap_entry = exception_valid | interrupt_taken;

    ////////////////////////////////////////////////////////////////////////////
    // Status, enables and pending

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (wr_en(csr_pkg::CSR_MSTATUS)) begin
            mstatus_mie <= wdata[csr_pkg::MIE_BIT];
            mstatus_mpie <= wdata[csr_pkg::MPIE_BIT];
        end else if (trap_entry) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
        end else if (mret) begin
            mstatus_mie <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
            mip <= '0;
            interrupt_cause <= '0;
        end else begin
            if (wr_en(csr_pkg::CSR_MIE)) begin
                mie <= {wdata[csr_pkg::MPP_LSB], wdata[csr_pkg::MPIE_BIT],
                        wdata[csr_pkg::MIE_BIT]};
            end
            mip <= {m_external, m_timer, m_software};
            // Sampled alongside mip with external over timer over software
            if (m_external & mie[2]) begin
                interrupt_cause <= csr_pkg::M_EXTERNAL_INT;
            end else if (m_timer & mie[1]) begin
                interrupt_cause <= csr_pkg::M_TIMER_INT;
            end else if (m_software & mie[0]) begin
                interrupt_cause <= csr_pkg::M_SOFTWARE_INT;
            end
        end
    end

    assign interrupt_pending = |(mip & mie);

    ////////////////////////////////////////////////////////////////////////////
    // Trap handling registers

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_int <= 1'b0;
            mcause_code <= '0;
        end else if (wr_en(csr_pkg::CSR_MCAUSE)) begin
            if (mcause_legal(wdata)) begin
                mcause_int <= wdata[csr_pkg::XLEN-1];
                mcause_code <= wdata[csr_pkg::ECODE_W-1:0];
            end
        end else if (interrupt_taken) begin
            mcause_int <= 1'b1;
            mcause_code <= interrupt_cause;
        end else if (exception_valid) begin
            mcause_int <= 1'b0;
            mcause_code <= exception_code;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en(csr_pkg::CSR_MTVEC)) begin
            mtvec <= wdata[csr_pkg::XLEN-1:2];
        end
        if (wr_en(csr_pkg::CSR_MEPC)) begin
            mepc <= wdata[csr_pkg::XLEN-1:2];
        end else if (exception_valid) begin
            mepc <= exception_pc[csr_pkg::XLEN-1:2];
        end
        if (wr_en(csr_pkg::CSR_MTVAL)) begin
            mtval <= wdata;
        end else if (exception_valid) begin
            mtval <= exception_tval;
        end
        if (wr_en(csr_pkg::CSR_MSCRATCH)) begin
            mscratch <= wdata;
        end
    end

    assign exception_target_pc = {mtvec, 2'b00};
    assign epc = {mepc, 2'b00};

    ////////////////////////////////////////////////////////////////////////////
    // Read mux

    always_comb begin
        case (bus.addr)
            csr_pkg::CSR_MSTATUS: begin
                bus.trap_rdata = '0;
                bus.trap_rdata[csr_pkg::MIE_BIT] = mstatus_mie;
                bus.trap_rdata[csr_pkg::MPIE_BIT] = mstatus_mpie;
                // mpp always reads as machine
                bus.trap_rdata[csr_pkg::MPP_LSB +: 2] = 2'b11;
            end
            csr_pkg::CSR_MISA: bus.trap_rdata = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MHARTID: bus.trap_rdata = csr_pkg::HART_ID;
            csr_pkg::CSR_MIE: bus.trap_rdata = irq_word(mie);
            csr_pkg::CSR_MIP: bus.trap_rdata = irq_word(mip);
            csr_pkg::CSR_MTVEC: bus.trap_rdata = exception_target_pc;
            csr_pkg::CSR_MEPC: bus.trap_rdata = epc;
            csr_pkg::CSR_MCAUSE: begin
                bus.trap_rdata = '0;
                bus.trap_rdata[csr_pkg::XLEN-1] = mcause_int;
                bus.trap_rdata[csr_pkg::ECODE_W-1:0] = mcause_code;
            end
            csr_pkg::CSR_MTVAL: bus.trap_rdata = mtval;
            csr_pkg::CSR_MSCRATCH: bus.trap_rdata = mscratch;
            default: bus.trap_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) !(exception_valid && mret))
        else $error("exception and mret in the same cycle");

endmodule

// File: source/csr_unit.sv
/* Machine-mode CSR unit top level */

`timescale 1ns/1ns

module csr_unit (
    input logic clk,
    input logic rst,

    // Issue
    input logic issue_valid,
    input csr_pkg::csr_op_e issue_op,
    input logic [11:0] issue_addr,
    input logic [csr_pkg::XLEN-1:0] issue_data,
    output logic ready,

    // Writeback
    output logic done,
    output logic [csr_pkg::XLEN-1:0] rd,
    input logic ack,

    // Trap control
    input logic exception_valid,
    input csr_pkg::ecode_e exception_code,
    input logic [csr_pkg::XLEN-1:0] exception_pc,
    input logic [csr_pkg::XLEN-1:0] exception_tval,
    input logic mret,
    input logic interrupt_taken,
    input logic m_software,
    input logic m_timer,
    input logic m_external,
    input logic [csr_pkg::RETIRE_W-1:0] retire_count,

    output logic [csr_pkg::XLEN-1:0] exception_target_pc,
    output logic [csr_pkg::XLEN-1:0] epc,
    output logic interrupt_pending,
    output logic processing_csr
);

    csr_access_if bus ();

    csr_request_ctrl request_ctrl (
        .clk (clk),
        .rst (rst),
        .issue_valid (issue_valid),
        .issue_op (issue_op),
        .issue_addr (issue_addr),
        .issue_data (issue_data),
        .ready (ready),
        .done (done),
        .rd (rd),
        .ack (ack),
        .processing_csr (processing_csr),
        .bus (bus.ctrl)
    );

    csr_trap_regs trap_regs (
        .clk (clk),
        .rst (rst),
        .exception_valid (exception_valid),
        .exception_code (exception_code),
        .exception_pc (exception_pc),
        .exception_tval (exception_tval),
        .mret (mret),
        .interrupt_taken (interrupt_taken),
        .m_software (m_software),
        .m_timer (m_timer),
        .m_external (m_external),
        .exception_target_pc (exception_target_pc),
        .epc (epc),
        .interrupt_pending (interrupt_pending),
        .bus (bus.trap)
    );

    csr_counters counters (
        .clk (clk),
        .rst (rst),
        .retire_count (retire_count),
        .bus (bus.counter)
    );

endmodule

// File: tests/csr_unit_tb.sv
/* Testbench for the CSR unit with a stimulus table, a reference model for
   mscratch and minstret, and random ack delays */

`timescale 1ns/1ns

module csr_unit_tb;

    localparam int TIMEOUT = 50;

    // Row kinds
    localparam logic [3:0] K_CSR = 4'd0;
    localparam logic [3:0] K_EXC = 4'd1;
    localparam logic [3:0] K_MRET = 4'd2;
    localparam logic [3:0] K_IRQ = 4'd3;
    localparam logic [3:0] K_TAKE = 4'd4;
    localparam logic [3:0] K_RETIRE = 4'd5;
    localparam logic [3:0] K_CYC_UP = 4'd6;
    localparam logic [3:0] K_CYC_NEAR = 4'd7;
    localparam logic [3:0] K_INSTRET = 4'd8;

    localparam logic [31:0] ALL = 32'hFFFF_FFFF;

    // K_EXC keeps the code in addr and K_RETIRE keeps the cycle count there
    typedef struct packed {
        logic [3:0] kind;
        logic [1:0] op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] mask;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    csr_pkg::csr_op_e issue_op;
    logic [11:0] issue_addr;
    logic [31:0] issue_data;
    logic ready;
    logic done;
    logic [31:0] rd;
    logic ack;
    logic exception_valid;
    csr_pkg::ecode_e exception_code;
    logic [31:0] exception_pc;
    logic [31:0] exception_tval;
    logic mret;
    logic interrupt_taken;
    logic m_software;
    logic m_timer;
    logic m_external;
    logic [1:0] retire_count;
    logic [31:0] exception_target_pc;
    logic [31:0] epc;
    logic interrupt_pending;
    logic processing_csr;

    row_t rows[$];
    int error_count = 0;
    logic [31:0] lfsr_state = 32'h958c;

    // Reference state
    logic [31:0] scratch_model;
    logic scratch_valid = 1'b0;
    logic [31:0] instret_model = 32'h0;
    logic [31:0] last_cycle;
    logic cycle_seen = 1'b0;

    csr_unit dut0 (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic pick_ack_delay(output int delay);
        logic [1:0] bits;
        bits = 2'b00;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[0], lfsr_state[0]};
        end
        delay = int'(bits);
    endtask

    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] old,
                                             input logic [31:0] data);
        if (op == csr_pkg::CSR_RS) begin
            return old | data;
        end
        if (op == csr_pkg::CSR_RC) begin
            return old & ~data;
        end
        return data;
    endfunction

    // One full issue, writeback and ack with handshake checks along the way
    task automatic csr_access(input logic [1:0] op, input logic [11:0] addr,
                              input logic [31:0] data, output logic [31:0] result);
        int cycles;
        int delay;
        logic [31:0] held;
        cycles = 0;
        while (!ready) begin
            if (cycles >= TIMEOUT) begin
                report_timeout("ready before issue");
            end
            next_cycle();
            cycles++;
        end
        issue_valid = 1'b1;
        issue_op = csr_pkg::csr_op_e'(op);
        issue_addr = addr;
        issue_data = data;
        next_cycle();
        issue_valid = 1'b0;
        cycles = 0;
        while (!done) begin
            check_value("ready", 32'(ready), 32'd0);
            check_value("processing_csr", 32'(processing_csr), 32'd1);
            if (cycles >= TIMEOUT) begin
                report_timeout("done");
            end
            next_cycle();
            cycles++;
        end
        held = rd;
        pick_ack_delay(delay);
        // Writeback must hold under back-pressure
        repeat (delay) begin
            next_cycle();
            check_value("done", 32'(done), 32'd1);
            check_value("rd", rd, held);
            check_value("ready", 32'(ready), 32'd0);
        end
        ack = 1'b1;
        next_cycle();
        ack = 1'b0;
        check_value("done", 32'(done), 32'd0);
        check_value("ready", 32'(ready), 32'd1);
        result = held;
    endtask

    task automatic add_row(input logic [3:0] kind, input logic [1:0] op, input logic [11:0] addr,
                           input logic [31:0] data, input logic [31:0] exp_val,
                           input logic [31:0] mask);
        rows.push_back({kind, op, addr, data, exp_val, mask});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic build_rows();
        // mscratch read-modify-write with rd from the model
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 32'hA5A5_0F0F, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 32'h0000_F0F0, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RC, csr_pkg::CSR_MSCRATCH, 32'hA000_0001, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 32'h1234_5678, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 32'h0, 32'h0, 32'h0);

        // Write protection and WARL fields
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MISA, 32'h0, csr_pkg::MISA_VALUE, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MISA, 32'h0, csr_pkg::MISA_VALUE, ALL);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MHARTID, ALL, csr_pkg::HART_ID, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MHARTID, 32'h0, csr_pkg::HART_ID, ALL);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_CYCLEH, ALL, 32'h0, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MCYCLEH, 32'h0, 32'h0, ALL);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_INSTRETH, ALL, 32'h0, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MINSTRETH, 32'h0, 32'h0, ALL);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MTVEC, 32'h1234_5677, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MTVEC, 32'h0, 32'h1234_5674, ALL);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MIE, ALL, 32'h0, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MIE, 32'h0, 32'h0000_0888, ALL);

        // Counters
        add_row(K_CYC_UP, csr_pkg::CSR_RS, csr_pkg::CSR_CYCLE, 32'h0, 32'h0, 32'h0);
        add_row(K_CYC_UP, csr_pkg::CSR_RS, csr_pkg::CSR_CYCLE, 32'h0, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MCYCLE, 32'h0001_0000, 32'h0, 32'h0);
        add_row(K_CYC_NEAR, csr_pkg::CSR_RS, csr_pkg::CSR_CYCLE, 32'h0, 32'h0001_0000, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MINSTRET, 32'h0, 32'h0, 32'h0);
        add_row(K_RETIRE, csr_pkg::CSR_RW, 12'd3, 32'd1, 32'h0, 32'h0);
        add_row(K_RETIRE, csr_pkg::CSR_RW, 12'd5, 32'd2, 32'h0, 32'h0);
        add_row(K_RETIRE, csr_pkg::CSR_RW, 12'd2, 32'd2, 32'h0, 32'h0);
        add_row(K_INSTRET, csr_pkg::CSR_RS, csr_pkg::CSR_INSTRET, 32'h0, 32'h0, 32'h0);
        add_row(K_RETIRE, csr_pkg::CSR_RW, 12'd4, 32'd2, 32'h0, 32'h0);
        add_row(K_INSTRET, csr_pkg::CSR_RS, csr_pkg::CSR_INSTRET, 32'h0, 32'h0, 32'h0);

        // Exception entry and mret
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h8, 32'h0000_1800, ALL);
        add_row(K_EXC, csr_pkg::CSR_RW, 12'd11, 32'h8000_0123, 32'hDEAD_BEEF, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 32'h0000_000B, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MTVAL, 32'h0, 32'hDEAD_BEEF, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0, 32'h8000_0120, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 32'h0000_1880, ALL);
        add_row(K_MRET, csr_pkg::CSR_RW, 12'h0, 32'h0, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 32'h0000_1888, ALL);

        // Illegal mcause codes are dropped
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MCAUSE, 32'h0000_000A, 32'h0000_000B, ALL);
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MCAUSE, 32'h8000_0005, 32'h0000_000B, ALL);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 32'h0000_000B, ALL);

        // Interrupt rows carry {external, timer, software} in data
        add_row(K_CSR, csr_pkg::CSR_RW, csr_pkg::CSR_MIE, 32'h0000_0880, 32'h0000_0888, ALL);
        add_row(K_IRQ, csr_pkg::CSR_RW, 12'h0, 32'h2, 32'h1, 32'h0);
        add_row(K_IRQ, csr_pkg::CSR_RW, 12'h0, 32'h0, 32'h0, 32'h0);
        add_row(K_IRQ, csr_pkg::CSR_RW, 12'h0, 32'h1, 32'h0, 32'h0);
        add_row(K_IRQ, csr_pkg::CSR_RW, 12'h0, 32'h6, 32'h1, 32'h0);
        add_row(K_TAKE, csr_pkg::CSR_RW, 12'h0, 32'h0, 32'h0, 32'h0);
        add_row(K_IRQ, csr_pkg::CSR_RW, 12'h0, 32'h0, 32'h0, 32'h0);
        add_row(K_CSR, csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 32'h8000_000B, ALL);
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] got;
        int cycles;
        case (r.kind)
            K_CSR: begin
                csr_access(r.op, r.addr, r.data, got);
                if (r.addr == csr_pkg::CSR_MSCRATCH) begin
                    if (scratch_valid) begin
                        check_value("rd of mscratch", got, scratch_model);
                    end
                    scratch_model = apply_op(r.op, scratch_model, r.data);
                    scratch_valid = scratch_valid | (r.op == csr_pkg::CSR_RW);
                end else if (r.mask != 32'h0) begin
                    check_value($sformatf("rd of csr %h", r.addr), got & r.mask,
                                r.exp_val & r.mask);
                end
                if (r.addr == csr_pkg::CSR_MINSTRET && r.op == csr_pkg::CSR_RW) begin
                    instret_model = r.data;
                end
                if (r.addr == csr_pkg::CSR_MTVEC && r.mask != 32'h0) begin
                    check_value("exception_target_pc", exception_target_pc, r.exp_val);
                end
            end
            K_EXC: begin
                exception_valid = 1'b1;
                exception_code = csr_pkg::ecode_e'(r.addr[4:0]);
                exception_pc = r.data;
                exception_tval = r.exp_val;
                next_cycle();
                exception_valid = 1'b0;
                check_value("epc", epc, r.data & 32'hFFFF_FFFC);
            end
            K_MRET: begin
                mret = 1'b1;
                next_cycle();
                mret = 1'b0;
            end
            K_TAKE: begin
                interrupt_taken = 1'b1;
                next_cycle();
                interrupt_taken = 1'b0;
            end
            K_IRQ: begin
                {m_external, m_timer, m_software} = r.data[2:0];
                if (r.exp_val[0]) begin
                    cycles = 0;
                    do begin
                        next_cycle();
                        cycles++;
                    end while (!interrupt_pending && cycles < TIMEOUT);
                    if (!interrupt_pending) begin
                        report_timeout("interrupt_pending");
                    end
                end else begin
                    repeat (6) begin
                        next_cycle();
                        check_value("interrupt_pending", 32'(interrupt_pending), 32'd0);
                    end
                end
            end
            K_RETIRE: begin
                retire_count = r.data[1:0];
                repeat (int'(r.addr)) next_cycle();
                retire_count = 2'd0;
                instret_model = instret_model + r.data * 32'(r.addr);
            end
            K_CYC_UP: begin
                csr_access(r.op, r.addr, r.data, got);
                if (cycle_seen) begin
                    check_value("cycle increasing", 32'(got > last_cycle), 32'd1);
                end
                last_cycle = got;
                cycle_seen = 1'b1;
            end
            K_CYC_NEAR: begin
                csr_access(r.op, r.addr, r.data, got);
                check_value("cycle after write in range",
                            32'(got >= r.exp_val && got < r.exp_val + 32'd20), 32'd1);
            end
            K_INSTRET: begin
                csr_access(r.op, r.addr, r.data, got);
                check_value("instret", got, instret_model);
            end
            default: begin
                $display("Unknown row kind %0d in the stimulus table", r.kind);
                $display("Done: errors found");
                $fatal(1);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = csr_pkg::CSR_RW;
        issue_addr = 12'h0;
        issue_data = 32'h0;
        ack = 1'b0;
        exception_valid = 1'b0;
        exception_code = csr_pkg::ECALL_M;
        exception_pc = 32'h0;
        exception_tval = 32'h0;
        mret = 1'b0;
        interrupt_taken = 1'b0;
        m_software = 1'b0;
        m_timer = 1'b0;
        m_external = 1'b0;
        retire_count = 2'd0;
        build_rows();

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("done after reset", 32'(done), 32'd0);
        check_value("ready after reset", 32'(ready), 32'd1);
        check_value("interrupt_pending after reset", 32'(interrupt_pending), 32'd0);

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
